// ==== rtl/decode_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage constants
// Widths, instruction field positions and select encodings shared
// by the decode stage blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define WORD_WIDTH    16
`define REG_COUNT     8
`define OPCODE_WIDTH  5
`define ALU_OP_WIDTH  4
`define NOP_INSTR     16'h0800   // Opcode 00001 with all other bits clear
`define LINK_REG      3'd7       // Written by JAL and JALR

// Instruction fields
`define OPC_FIELD     15:11
`define RS_FIELD      10:8
`define RT_FIELD      7:5
`define RD_FIELD      4:2

// Destination select
`define RD_SEL_RS     2'd0
`define RD_SEL_RT     2'd1
`define RD_SEL_RD     2'd2
`define RD_SEL_LINK   2'd3

`endif

// ==== rtl/decode_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage types
// Word, register index, opcode and ALU op vectors, plus the packed
// control bundle handed from decode to the later stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_macros.svh"

package decode_pkg;

  typedef logic [`WORD_WIDTH-1:0]        word_t;     // Data or instruction
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_sel_t;  // Register index
  typedef logic [`OPCODE_WIDTH-1:0]      opcode_t;
  typedef logic [`ALU_OP_WIDTH-1:0]      alu_op_t;   // Low opcode bits

  // Write-back source
  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_MEM  = 2'd1;
  localparam logic [1:0] WB_PC   = 2'd2;   // Return address for links

  // Second ALU operand
  localparam logic [1:0] B_REG   = 2'd0;
  localparam logic [1:0] B_IMM5  = 2'd1;
  localparam logic [1:0] B_IMM8  = 2'd2;
  localparam logic [1:0] B_IMM11 = 2'd3;

  typedef struct packed {
    alu_op_t    alu_op;
    logic [1:0] wb_sel;     // WB_*
    logic [1:0] b_sel;      // B_*
    logic       reg_write;
    logic       mem_en;
    logic       mem_write;
    logic       branch;     // Conditional branch on Rs
    logic       set;        // SEQ, SLT, SLE, SCO
    logic       sub;
    logic       inv_a;
    logic       inv_b;
    logic       imm_sel;    // PC offset from imm11 instead of imm8
    logic       alu_jmp;    // Target computed by the ALU
    logic       slbi;
    logic       btr;
    logic       jmp;
    logic       halt;
  } ctrl_t;

endpackage

// ==== rtl/instruction_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Maps the 5-bit opcode to the control bundle, the immediate
// extension mode and the destination register select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "decode_macros.svh"

module instruction_decoder import decode_pkg::*; (
  input  opcode_t    opcode,
  output ctrl_t      ctrl,
  output logic       zero_ext,
  output logic [1:0] reg_dst
);

  always_comb begin
    ctrl     = '0;
    zero_ext = 1'b0;
    reg_dst  = `RD_SEL_RS;
    casez (opcode)
      5'b00000: begin                  // HALT
        ctrl.halt = 1'b1;
      end
      5'b00100: begin                  // J
        ctrl.alu_op  = opcode[3:0];
        ctrl.jmp     = 1'b1;
        ctrl.imm_sel = 1'b1;
      end
      5'b00101: begin                  // JR
        ctrl.alu_op  = opcode[3:0];
        ctrl.jmp     = 1'b1;
        ctrl.alu_jmp = 1'b1;
        ctrl.b_sel   = B_IMM8;
      end
      5'b00110: begin                  // JAL
        ctrl.alu_op    = opcode[3:0];
        ctrl.jmp       = 1'b1;
        ctrl.imm_sel   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_PC;
        reg_dst        = `RD_SEL_LINK;
      end
      5'b00111: begin                  // JALR
        ctrl.alu_op    = opcode[3:0];
        ctrl.jmp       = 1'b1;
        ctrl.alu_jmp   = 1'b1;
        ctrl.b_sel     = B_IMM8;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_PC;
        reg_dst        = `RD_SEL_LINK;
      end
      5'b010??: begin                  // ADDI, SUBI, XORI, ANDNI
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM5;
        ctrl.reg_write = 1'b1;
        ctrl.sub       = (opcode[1:0] == 2'b01);
        ctrl.inv_a     = (opcode[1:0] == 2'b01);   // Imm minus Rs
        ctrl.inv_b     = (opcode[1:0] == 2'b11);
        zero_ext       = opcode[1];                // Logic ops take unsigned imm
        reg_dst        = `RD_SEL_RT;
      end
      5'b011??: begin                  // BEQZ, BNEZ, BLTZ, BGEZ
        ctrl.alu_op = opcode[3:0];
        ctrl.branch = 1'b1;
      end
      5'b10000: begin                  // ST
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM5;
        ctrl.mem_en    = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      5'b10001: begin                  // LD
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM5;
        ctrl.mem_en    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_MEM;
        reg_dst        = `RD_SEL_RT;
      end
      5'b10010: begin                  // SLBI
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM8;
        ctrl.slbi      = 1'b1;
        ctrl.reg_write = 1'b1;
        zero_ext       = 1'b1;
      end
      5'b10011: begin                  // STU writes the address back to Rs
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM5;
        ctrl.mem_en    = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      5'b101??: begin                  // ROLI, SLLI, RORI, SRLI
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM5;
        ctrl.reg_write = 1'b1;
        reg_dst        = `RD_SEL_RT;
      end
      5'b11000: begin                  // LBI
        ctrl.alu_op    = opcode[3:0];
        ctrl.b_sel     = B_IMM8;
        ctrl.reg_write = 1'b1;
      end
      5'b11001: begin                  // BTR
        ctrl.alu_op    = opcode[3:0];
        ctrl.btr       = 1'b1;
        ctrl.reg_write = 1'b1;
        reg_dst        = `RD_SEL_RD;
      end
      5'b11011: begin                  // ADD, SUB, XOR, ANDN by function bits
        ctrl.alu_op    = opcode[3:0];
        ctrl.reg_write = 1'b1;
        reg_dst        = `RD_SEL_RD;
      end
      5'b111??: begin                  // SEQ, SLT, SLE, SCO
        ctrl.alu_op    = opcode[3:0];
        ctrl.set       = 1'b1;
        ctrl.sub       = 1'b1;
        ctrl.inv_b     = 1'b1;
        ctrl.reg_write = 1'b1;
        reg_dst        = `RD_SEL_RD;
      end
      default: begin                   // NOP and unused codes decode as bubbles
      end
    endcase
  end

  a_mem_write_en: assert final (!ctrl.mem_write || ctrl.mem_en)
    else $error("mem_write without mem_en, opcode %b", opcode);

endmodule

// ==== rtl/reg_file_bypass.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file with write-through bypass
// Eight words, two read ports and one write port; a read of the
// index being written returns the new data in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "decode_macros.svh"

module reg_file_bypass import decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_sel_t rd1_sel,
  input  reg_sel_t rd2_sel,
  input  reg_sel_t wr_sel,
  input  word_t    wr_data,
  input  logic     wr_en,
  output word_t    rd1_data,
  output word_t    rd2_data
);

  word_t regs [`REG_COUNT];   // R0 is writable like the rest

  logic  hit1;
  logic  hit2;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  assign hit1 = wr_en && (wr_sel == rd1_sel);   // Write-back in flight
  assign hit2 = wr_en && (wr_sel == rd2_sel);

  assign rd1_data = hit1 ? wr_data : regs[rd1_sel];
  assign rd2_data = hit2 ? wr_data : regs[rd2_sel];

  // Write strobe must come with a real index
  a_wr_sel_known: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_sel)
  ) else $error("register write with unknown index");

endmodule

// ==== rtl/hazard_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit
// Flags load-use hazards and flushes, keeps the previous fetch for
// replay and picks the instruction that decode works on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "decode_macros.svh"

module hazard_unit import decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    instruction_fd,
  input  logic     ex_mem_read,
  input  reg_sel_t ex_rt,
  input  logic     pc_src,
  input  logic     dmem_stall,
  input  logic     imem_stall,
  output word_t    instruction_d,
  output logic     data_hazard,
  output logic     flush
);

  reg_sel_t fd_rs;
  reg_sel_t fd_rt;
  word_t    held_instr;    // Fetch from the previous cycle
  logic     hazard_prev;
  logic     replay;

  assign fd_rs = instruction_fd[`RS_FIELD];
  assign fd_rt = instruction_fd[`RT_FIELD];

  assign flush = pc_src;   // Taken branch squashes the fetched word

  // Load in execute feeds a source of the fetched instruction
  assign data_hazard = ex_mem_read && !dmem_stall && !imem_stall &&
                       ((ex_rt == fd_rs) || (ex_rt == fd_rt));

  always_ff @(posedge clk) begin
    if (reset) begin
      held_instr  <= `NOP_INSTR;
      hazard_prev <= 1'b0;
    end else begin
      held_instr  <= instruction_fd;
      hazard_prev <= data_hazard;
    end
  end

  assign replay = hazard_prev && (held_instr != `NOP_INSTR);

  always_comb begin
    if (data_hazard || flush || dmem_stall) begin
      instruction_d = `NOP_INSTR;   // Bubble
    end else if (replay) begin
      instruction_d = held_instr;
    end else begin
      instruction_d = instruction_fd;
    end
  end

  a_flush_nop: assert property (
    @(posedge clk) disable iff (reset)
    flush |-> (instruction_d == `NOP_INSTR)
  ) else $error("flush did not insert a bubble");

endmodule

// ==== rtl/decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Selects the instruction, decodes it, reads the register file and
// extends the immediates for the execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_stage import decode_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  word_t      instruction_fd,
  input  logic       wb_write,
  input  reg_sel_t   wb_sel_reg,
  input  word_t      wb_data,
  input  logic       ex_mem_read,
  input  reg_sel_t   ex_rt,
  input  logic       pc_src,
  input  logic       dmem_stall,
  input  logic       imem_stall,
  output ctrl_t      ctrl,
  output word_t      read1_data,
  output word_t      read2_data,
  output word_t      imm5_ext,
  output word_t      imm8_ext,
  output word_t      imm11_ext,
  output reg_sel_t   write_reg,
  output reg_sel_t   rs,
  output reg_sel_t   rt,
  output logic [1:0] extension,
  output logic [1:0] branch_sel,
  output word_t      instruction_d,
  output logic       data_hazard,
  output logic       flush
);

  logic       zero_ext;
  logic [1:0] reg_dst;
  logic       fill5;       // Upper bits for imm5
  logic       fill8;       // Upper bits for imm8

  hazard_unit hazard0 (
    .clk            (clk),
    .reset          (reset),
    .instruction_fd (instruction_fd),
    .ex_mem_read    (ex_mem_read),
    .ex_rt          (ex_rt),
    .pc_src         (pc_src),
    .dmem_stall     (dmem_stall),
    .imem_stall     (imem_stall),
    .instruction_d  (instruction_d),
    .data_hazard    (data_hazard),
    .flush          (flush)
  );

  instruction_decoder decoder0 (
    .opcode   (instruction_d[`OPC_FIELD]),
    .ctrl     (ctrl),
    .zero_ext (zero_ext),
    .reg_dst  (reg_dst)
  );

  assign rs = instruction_d[`RS_FIELD];
  assign rt = instruction_d[`RT_FIELD];

  reg_file_bypass regfile0 (
    .clk      (clk),
    .reset    (reset),
    .rd1_sel  (rs),
    .rd2_sel  (rt),
    .wr_sel   (wb_sel_reg),
    .wr_data  (wb_data),
    .wr_en    (wb_write),
    .rd1_data (read1_data),
    .rd2_data (read2_data)
  );

  assign fill5 = zero_ext ? 1'b0 : instruction_d[4];
  assign fill8 = zero_ext ? 1'b0 : instruction_d[7];

  assign imm5_ext  = {{(`WORD_WIDTH-5){fill5}}, instruction_d[4:0]};
  assign imm8_ext  = {{(`WORD_WIDTH-8){fill8}}, instruction_d[7:0]};
  assign imm11_ext = {{(`WORD_WIDTH-11){instruction_d[10]}}, instruction_d[10:0]};   // Always signed

  always_comb begin
    case (reg_dst)
      `RD_SEL_RS: write_reg = instruction_d[`RS_FIELD];
      `RD_SEL_RT: write_reg = instruction_d[`RT_FIELD];
      `RD_SEL_RD: write_reg = instruction_d[`RD_FIELD];
      default:    write_reg = `LINK_REG;   // JAL, JALR
    endcase
  end

  // Raw fields for execute
  assign extension  = instruction_d[1:0];     // R-type function
  assign branch_sel = instruction_d[12:11];   // Branch condition

endmodule

// ==== test/decode_stage_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage testbench
// Random stimulus against a reference model of instruction select,
// decode table, immediates and register file, checked by assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_stage_tb import decode_pkg::*; ();

  localparam int MODE_REGS   = 0;
  localparam int MODE_DECODE = 1;
  localparam int MODE_HAZARD = 2;

  typedef struct packed {
    logic       reg_write;
    logic       zero_ext;
    logic [1:0] dst;         // Destination field class
  } ref_dec_t;

  logic       clk;
  logic       reset;
  word_t      instruction_fd;
  logic       wb_write;
  reg_sel_t   wb_sel_reg;
  word_t      wb_data;
  logic       ex_mem_read;
  reg_sel_t   ex_rt;
  logic       pc_src;
  logic       dmem_stall;
  logic       imem_stall;
  ctrl_t      ctrl;
  word_t      read1_data, read2_data, instruction_d;
  word_t      imm5_ext, imm8_ext, imm11_ext;
  reg_sel_t   write_reg, rs, rt;
  logic [1:0] extension, branch_sel;
  logic       data_hazard, flush;

  word_t       shadow [`REG_COUNT];   // Testbench copy of the register file
  word_t       prev_fd;
  logic        prev_hazard;
  logic        src_match;
  logic        exp_hazard;
  word_t       exp_instr_d;
  ref_dec_t    exp_dec;
  word_t       exp_imm5, exp_imm8, exp_imm11, exp_read1, exp_read2;
  reg_sel_t    exp_write_reg;
  logic [31:0] rng_state;
  int          error_count;
  int          bypass_hits, hazard_hits, replay_hits, flush_hits, dstall_hits, istall_hits;

  decode_stage dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Destination class, write enable and extension mode per opcode
  function automatic ref_dec_t expected_decode(input opcode_t opc);
    ref_dec_t r;
    r = '0;
    case (opc)
      5'b11011, 5'b11100, 5'b11101, 5'b11110, 5'b11111, 5'b11001: r = {2'b10, `RD_SEL_RD};
      5'b01000, 5'b01001, 5'b10001: r = {2'b10, `RD_SEL_RT};
      5'b10100, 5'b10101, 5'b10110, 5'b10111: r = {2'b10, `RD_SEL_RT};
      5'b01010, 5'b01011: r = {2'b11, `RD_SEL_RT};
      5'b11000, 5'b10011: r = {2'b10, `RD_SEL_RS};
      5'b10010: r = {2'b11, `RD_SEL_RS};           // SLBI
      5'b00110, 5'b00111: r = {2'b10, `RD_SEL_LINK};
      default: r = '0;
    endcase
    return r;
  endfunction

  assign src_match  = (ex_rt == instruction_fd[`RS_FIELD]) || (ex_rt == instruction_fd[`RT_FIELD]);
  assign exp_hazard = ex_mem_read && !(dmem_stall || imem_stall) && src_match;

  always_comb begin
    exp_instr_d = instruction_fd;
    if (exp_hazard || pc_src || dmem_stall) begin
      exp_instr_d = `NOP_INSTR;
    end else if (prev_hazard && (prev_fd != `NOP_INSTR)) begin
      exp_instr_d = prev_fd;                   // Replay after a load-use stall
    end
  end

  assign exp_dec   = expected_decode(exp_instr_d[`OPC_FIELD]);
  assign exp_imm5  = exp_dec.zero_ext ? word_t'(exp_instr_d[4:0])
                                      : word_t'($signed(exp_instr_d[4:0]));
  assign exp_imm8  = exp_dec.zero_ext ? word_t'(exp_instr_d[7:0])
                                      : word_t'($signed(exp_instr_d[7:0]));
  assign exp_imm11 = word_t'($signed(exp_instr_d[10:0]));

  always_comb begin
    case (exp_dec.dst)
      `RD_SEL_RS: exp_write_reg = exp_instr_d[`RS_FIELD];
      `RD_SEL_RT: exp_write_reg = exp_instr_d[`RT_FIELD];
      `RD_SEL_RD: exp_write_reg = exp_instr_d[`RD_FIELD];
      default:    exp_write_reg = `LINK_REG;
    endcase
  end

  assign exp_read1 = (wb_write && (wb_sel_reg == exp_instr_d[`RS_FIELD]))
                     ? wb_data : shadow[exp_instr_d[`RS_FIELD]];
  assign exp_read2 = (wb_write && (wb_sel_reg == exp_instr_d[`RT_FIELD]))
                     ? wb_data : shadow[exp_instr_d[`RT_FIELD]];

  always @(posedge clk) begin
    if (reset) begin
      prev_fd     <= `NOP_INSTR;
      prev_hazard <= 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      prev_fd     <= instruction_fd;
      prev_hazard <= exp_hazard;
      if (wb_write) begin
        shadow[wb_sel_reg] <= wb_data;
      end
    end
  end

  // Stimulus coverage, used to end the phases
  always @(posedge clk) begin
    if (reset) begin
      bypass_hits <= 0;
      hazard_hits <= 0;
      replay_hits <= 0;
      flush_hits  <= 0;
      dstall_hits <= 0;
      istall_hits <= 0;
    end else begin
      if (wb_write && ((wb_sel_reg == exp_instr_d[`RS_FIELD]) ||
                       (wb_sel_reg == exp_instr_d[`RT_FIELD])))
        bypass_hits <= bypass_hits + 1;
      if (exp_hazard)
        hazard_hits <= hazard_hits + 1;
      if (prev_hazard && (prev_fd != `NOP_INSTR) && !exp_hazard && !pc_src && !dmem_stall)
        replay_hits <= replay_hits + 1;
      if (pc_src)
        flush_hits <= flush_hits + 1;
      if (dmem_stall && !pc_src)
        dstall_hits <= dstall_hits + 1;
      if (imem_stall && !dmem_stall && ex_mem_read && src_match)
        istall_hits <= istall_hits + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    $display("Done: errors found");
    $fatal(1, "check %s failed", name);
  endtask

  task automatic abort_timeout(input string phase);
    error_count++;
    $display("Timeout in %s, stimulus never reached its targets", phase);
    $display("Done: errors found");
    $fatal(1, "phase %s timed out", phase);
  endtask

  a_flush: assert property (@(posedge clk) disable iff (reset) flush == pc_src)
    else report_mismatch("flush", $sampled(pc_src), $sampled(flush));
  a_hazard: assert property (@(posedge clk) disable iff (reset) data_hazard == exp_hazard)
    else report_mismatch("data_hazard", $sampled(exp_hazard), $sampled(data_hazard));
  a_instr_sel: assert property (@(posedge clk) disable iff (reset) instruction_d == exp_instr_d)
    else report_mismatch("instr_select", $sampled(exp_instr_d), $sampled(instruction_d));
  a_nop_ctrl: assert property (@(posedge clk) disable iff (reset)
    (exp_instr_d == `NOP_INSTR) |-> (ctrl == '0))
    else report_mismatch("nop_ctrl", 32'd0, $sampled(ctrl));
  a_read1: assert property (@(posedge clk) disable iff (reset) read1_data == exp_read1)
    else report_mismatch("read1", $sampled(exp_read1), $sampled(read1_data));
  a_read2: assert property (@(posedge clk) disable iff (reset) read2_data == exp_read2)
    else report_mismatch("read2", $sampled(exp_read2), $sampled(read2_data));
  a_imm5: assert property (@(posedge clk) disable iff (reset) imm5_ext == exp_imm5)
    else report_mismatch("imm5", $sampled(exp_imm5), $sampled(imm5_ext));
  a_imm8: assert property (@(posedge clk) disable iff (reset) imm8_ext == exp_imm8)
    else report_mismatch("imm8", $sampled(exp_imm8), $sampled(imm8_ext));
  a_imm11: assert property (@(posedge clk) disable iff (reset) imm11_ext == exp_imm11)
    else report_mismatch("imm11", $sampled(exp_imm11), $sampled(imm11_ext));
  a_reg_write: assert property (@(posedge clk) disable iff (reset)
    ctrl.reg_write == exp_dec.reg_write)
    else report_mismatch("reg_write", $sampled(exp_dec.reg_write), $sampled(ctrl.reg_write));
  a_write_reg: assert property (@(posedge clk) disable iff (reset)
    exp_dec.reg_write |-> (write_reg == exp_write_reg))
    else report_mismatch("write_reg", $sampled(exp_write_reg), $sampled(write_reg));
  a_raw_fields: assert property (@(posedge clk) disable iff (reset)
    {rs, rt, extension, branch_sel} == {exp_instr_d[10:5], exp_instr_d[1:0], exp_instr_d[12:11]})
    else report_mismatch("raw_fields", $sampled({exp_instr_d[10:5], exp_instr_d[1:0],
                         exp_instr_d[12:11]}), $sampled({rs, rt, extension, branch_sel}));

  task automatic draw(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  task automatic drive_idle();
    instruction_fd = `NOP_INSTR;
    wb_write       = 1'b0;
    wb_sel_reg     = '0;
    wb_data        = '0;
    ex_mem_read    = 1'b0;
    ex_rt          = '0;
    pc_src         = 1'b0;
    dmem_stall     = 1'b0;
    imem_stall     = 1'b0;
  endtask

  task automatic drive_random(input int mode, input opcode_t opc);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    draw(r1);
    draw(r2);
    draw(r3);
    instruction_fd = r1[15:0];
    wb_write       = (r2[1:0] != 2'b00);
    wb_data        = r2[31:16];
    wb_sel_reg     = r2[2] ? instruction_fd[`RS_FIELD] : r2[5:3];   // Aim at the read port
    ex_mem_read    = 1'b0;
    ex_rt          = r3[2:0];
    pc_src         = 1'b0;
    dmem_stall     = 1'b0;
    imem_stall     = 1'b0;
    case (mode)
      MODE_REGS:   instruction_fd[`OPC_FIELD] = 5'b11011;
      MODE_DECODE: instruction_fd[`OPC_FIELD] = opc;
      default: begin
        ex_mem_read = r3[3];
        if (r3[4])
          ex_rt = r3[5] ? instruction_fd[`RS_FIELD] : instruction_fd[`RT_FIELD];
        pc_src     = (r3[8:6] == 3'd0);
        dmem_stall = (r3[11:9] == 3'd0);
        imem_stall = (r3[14:12] == 3'd0);
      end
    endcase
  endtask

  initial begin
    int cycles;
    clk         = 1'b0;
    reset       = 1'b1;
    rng_state   = 32'ha86d1829;
    error_count = 0;
    drive_idle();
    for (int i = 0; i < 16; i++) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 4; i++) @(negedge clk);   // NOP after reset, all zero

    cycles = 0;
    while (bypass_hits < 12) begin
      if (cycles == 400) abort_timeout("register bypass phase");
      @(negedge clk);
      drive_random(MODE_REGS, '0);
      cycles++;
    end

    for (int op = 0; op < 32; op++) begin
      for (int n = 0; n < 4; n++) begin
        @(negedge clk);
        drive_random(MODE_DECODE, opcode_t'(op));
        if (n == 0) begin
          instruction_fd[4] = 1'b1;   // Sign bits set so the extension mode shows
          instruction_fd[7] = 1'b1;
        end
      end
    end

    cycles = 0;
    while (hazard_hits < 10 || replay_hits < 5 || flush_hits < 4 ||
           dstall_hits < 4 || istall_hits < 4) begin
      if (cycles == 3000) abort_timeout("hazard phase");
      @(negedge clk);
      drive_random(MODE_HAZARD, '0);
      cycles++;
    end

    @(negedge clk);
    drive_idle();
    for (int i = 0; i < 3; i++) @(negedge clk);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== wisc_decode.f ====
+incdir+rtl
rtl/decode_pkg.sv
rtl/instruction_decoder.sv
rtl/reg_file_bypass.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
test/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: wisc_decode

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/decode_pkg.sv
      - rtl/instruction_decoder.sv
      - rtl/reg_file_bypass.sv
      - rtl/hazard_unit.sv
      - rtl/decode_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/decode_stage_tb.sv
